/* bpu_pkg.sv */
package bpu_pkg;

    // datapath widths
    localparam int XLEN   = 32;
    localparam int HIST_W = 16;    // global history length
    localparam int CTR_W  = 2;

    // bimodal table, indexed by pc[9:1]
    localparam int BIM_ENTRIES = 512;
    localparam int BIM_IDX_W   = 9;

    // tagged tables T0 and T1
    localparam int TAGE_ENTRIES = 256;
    localparam int TAGE_IDX_W   = 8;
    localparam int TAG_W        = 10;
    localparam int PTAG_W       = 6;    // upper tag bits used for the match

    // btb, index pc[9:2], tag pc[31:10]
    localparam int BTB_ENTRIES = 256;
    localparam int BTB_IDX_W   = 8;
    localparam int BTB_TAG_W   = 22;

    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    typedef logic [CTR_W-1:0] ctr_t;

    localparam ctr_t CTR_INIT = 2'b01;    // weakly not taken

    typedef enum logic [1:0] {
        PROV_BIM = 2'd0,
        PROV_T0  = 2'd1,
        PROV_T1  = 2'd2
    } provider_e;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
    } bpu_fetch_t;

    typedef struct packed {
        logic              is_ctrl;
        logic              taken;
        logic [XLEN-1:0]   target;
        provider_e         provider;    // returned with the feedback
        logic [HIST_W-1:0] history;     // history seen by this lookup
    } bpu_pred_t;

    typedef struct packed {
        logic              valid;
        logic              taken;       // resolved outcome
        logic              pred_taken;
        provider_e         provider;
        logic [XLEN-1:0]   pc;
        logic [HIST_W-1:0] history;
        logic [XLEN-1:0]   target;      // resolved target
    } bpu_feedback_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        ctr_t             ctr;
    } tage_entry_t;

    typedef struct packed {
        logic                 valid;
        logic [BTB_TAG_W-1:0] tag;
        logic [XLEN-1:0]      target;
    } btb_entry_t;

    // short history table
    function automatic void t0_hash(
        input  logic [XLEN-1:0]       pc,
        input  logic [HIST_W-1:0]     hist,
        output logic [TAGE_IDX_W-1:0] idx,
        output logic [TAG_W-1:0]      tag
    );
        idx = pc[7:0] ^ hist[7:0];
        tag = pc[17:8] ^ hist[15:6];
    endfunction

    // long history table, low history byte folded into the tag
    function automatic void t1_hash(
        input  logic [XLEN-1:0]       pc,
        input  logic [HIST_W-1:0]     hist,
        output logic [TAGE_IDX_W-1:0] idx,
        output logic [TAG_W-1:0]      tag
    );
        idx = pc[7:0] ^ hist[15:8];
        tag = pc[17:8] ^ TAG_W'(hist[7:0]);
    endfunction

endpackage

/* bpu_table.sv */
module bpu_table #(
    parameter type    entry_t   = logic,
    parameter int     DEPTH     = 256,
    parameter entry_t RESET_VAL = '0
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [$clog2(DEPTH)-1:0] rd_idx_i,
    output entry_t                   rd_data_o,
    input  logic                     wr_en_i,
    input  logic [$clog2(DEPTH)-1:0] wr_idx_i,
    input  entry_t                   wr_data_i,
    output entry_t                   wr_cur_o
);

    entry_t mem [DEPTH];

    assign rd_data_o = mem[rd_idx_i];    // lookup port
    assign wr_cur_o  = mem[wr_idx_i];    // current entry, for read-modify-write

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= RESET_VAL;
            end
        end else if (wr_en_i) begin
            mem[wr_idx_i] <= wr_data_i;
        end
    end

    // an X on the enable would corrupt an unknown entry
    wr_en_known_a: assert property (
        @(posedge clk) disable iff (rst) !$isunknown(wr_en_i)
    );

endmodule

/* bpu_predecode.sv */
module bpu_predecode (
    input  logic [bpu_pkg::XLEN-1:0] inst_i,
    output logic                     is_branch_o,
    output logic                     is_jal_o,
    output logic                     is_jalr_o,
    output logic                     is_ret_o,
    output logic [bpu_pkg::XLEN-1:0] br_off_o,
    output logic [bpu_pkg::XLEN-1:0] jal_off_o
);

    logic [6:0] opcode;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic       link_rs1;

    assign opcode   = inst_i[6:0];
    assign rd       = inst_i[11:7];
    assign rs1      = inst_i[19:15];
    assign link_rs1 = (rs1 == 5'd1) || (rs1 == 5'd5);    // ra or t0

    assign is_branch_o = (opcode == bpu_pkg::OP_BRANCH);
    assign is_jal_o    = (opcode == bpu_pkg::OP_JAL);
    assign is_jalr_o   = (opcode == bpu_pkg::OP_JALR);

    // jalr x0, 0(ra) and the t0 variant
    assign is_ret_o = is_jalr_o && (rd == 5'd0) && link_rs1 && (inst_i[31:20] == 12'd0);

    // B-type immediate
    assign br_off_o = {{19{inst_i[31]}}, inst_i[31], inst_i[7],
                       inst_i[30:25], inst_i[11:8], 1'b0};

    // J-type immediate
    assign jal_off_o = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12],
                        inst_i[20], inst_i[30:21], 1'b0};

endmodule

/* bpu_tage.sv */
module bpu_tage (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [bpu_pkg::XLEN-1:0]   pc_i,
    input  bpu_pkg::bpu_feedback_t     fb_i,
    output logic                       taken_o,
    output bpu_pkg::provider_e         provider_o,
    output logic [bpu_pkg::HIST_W-1:0] history_o
);

    logic [bpu_pkg::HIST_W-1:0] hist_q;

    // lookup side
    logic [bpu_pkg::BIM_IDX_W-1:0]  bim_idx;
    logic [bpu_pkg::TAGE_IDX_W-1:0] t0_idx;
    logic [bpu_pkg::TAGE_IDX_W-1:0] t1_idx;
    logic [bpu_pkg::TAG_W-1:0]      t0_tag;
    logic [bpu_pkg::TAG_W-1:0]      t1_tag;
    bpu_pkg::ctr_t                  bim_rd;
    bpu_pkg::tage_entry_t           t0_rd;
    bpu_pkg::tage_entry_t           t1_rd;
    logic                           t0_hit;
    logic                           t1_hit;

    // update side, all from the feedback
    logic [bpu_pkg::BIM_IDX_W-1:0]  bim_uidx;
    logic [bpu_pkg::TAGE_IDX_W-1:0] t0_uidx;
    logic [bpu_pkg::TAGE_IDX_W-1:0] t1_uidx;
    logic [bpu_pkg::TAG_W-1:0]      t0_utag;
    logic [bpu_pkg::TAG_W-1:0]      t1_utag;
    bpu_pkg::ctr_t                  bim_cur;
    bpu_pkg::ctr_t                  bim_wd;
    bpu_pkg::tage_entry_t           t0_cur;
    bpu_pkg::tage_entry_t           t1_cur;
    bpu_pkg::tage_entry_t           t0_wd;
    bpu_pkg::tage_entry_t           t1_wd;
    logic                           t0_we;
    logic                           t1_we;
    logic                           pred_ok;

    function automatic bpu_pkg::ctr_t ctr_step(bpu_pkg::ctr_t ctr, logic up);
        if (up) begin
            return (&ctr) ? ctr : ctr + 1'b1;
        end
        return (|ctr) ? ctr - 1'b1 : ctr;
    endfunction

    always_comb begin
        bpu_pkg::t0_hash(pc_i, hist_q, t0_idx, t0_tag);
        bpu_pkg::t1_hash(pc_i, hist_q, t1_idx, t1_tag);
        bpu_pkg::t0_hash(fb_i.pc, fb_i.history, t0_uidx, t0_utag);
        bpu_pkg::t1_hash(fb_i.pc, fb_i.history, t1_uidx, t1_utag);
    end

    assign bim_idx  = pc_i[bpu_pkg::BIM_IDX_W:1];
    assign bim_uidx = fb_i.pc[bpu_pkg::BIM_IDX_W:1];

    // partial tag match on the upper bits only
    assign t0_hit = t0_rd.valid && (t0_rd.tag[bpu_pkg::TAG_W-1 -: bpu_pkg::PTAG_W] ==
                                    t0_tag[bpu_pkg::TAG_W-1 -: bpu_pkg::PTAG_W]);
    assign t1_hit = t1_rd.valid && (t1_rd.tag[bpu_pkg::TAG_W-1 -: bpu_pkg::PTAG_W] ==
                                    t1_tag[bpu_pkg::TAG_W-1 -: bpu_pkg::PTAG_W]);

    always_comb begin
        if (t1_hit) begin
            provider_o = bpu_pkg::PROV_T1;
            taken_o    = t1_rd.ctr[bpu_pkg::CTR_W-1];
        end else if (t0_hit) begin
            provider_o = bpu_pkg::PROV_T0;
            taken_o    = t0_rd.ctr[bpu_pkg::CTR_W-1];
        end else begin
            provider_o = bpu_pkg::PROV_BIM;
            taken_o    = bim_rd[bpu_pkg::CTR_W-1];
        end
    end

    assign history_o = hist_q;
    assign pred_ok   = (fb_i.pred_taken == fb_i.taken);
    assign bim_wd    = ctr_step(bim_cur, fb_i.taken);    // bimodal trains on every branch

    always_comb begin
        t0_we = 1'b0;
        t1_we = 1'b0;
        t0_wd = t0_cur;
        t1_wd = t1_cur;
        if (fb_i.valid) begin
            if (pred_ok) begin
                case (fb_i.provider)
                    bpu_pkg::PROV_T1: begin
                        t1_we     = 1'b1;
                        t1_wd.ctr = ctr_step(t1_cur.ctr, fb_i.taken);
                    end
                    bpu_pkg::PROV_T0: begin
                        t0_we     = 1'b1;
                        t0_wd.ctr = ctr_step(t0_cur.ctr, fb_i.taken);
                    end
                    default: ;
                endcase
            end else begin
                case (fb_i.provider)
                    bpu_pkg::PROV_T1: begin
                        t1_we     = 1'b1;
                        t1_wd.ctr = {2{fb_i.taken}};    // jump to strong outcome
                    end
                    bpu_pkg::PROV_T0: begin
                        t0_we     = 1'b1;
                        t0_wd.ctr = {2{fb_i.taken}};
                    end
                    default: begin
                        // bimodal missed, allocate in the longer table first
                        if (!t1_cur.valid || (t1_cur.tag != t1_utag)) begin
                            t1_we = 1'b1;
                            t1_wd = '{valid: 1'b1, tag: t1_utag, ctr: {fb_i.taken, ~fb_i.taken}};
                        end else if (!t0_cur.valid || (t0_cur.tag != t0_utag)) begin
                            t0_we = 1'b1;
                            t0_wd = '{valid: 1'b1, tag: t0_utag, ctr: {fb_i.taken, ~fb_i.taken}};
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hist_q <= '0;
        end else if (fb_i.valid) begin
            hist_q <= {hist_q[bpu_pkg::HIST_W-2:0], fb_i.taken};
        end
    end

    bpu_table #(
        .entry_t   (bpu_pkg::ctr_t),
        .DEPTH     (bpu_pkg::BIM_ENTRIES),
        .RESET_VAL (bpu_pkg::CTR_INIT)
    ) u_bim (
        .clk       (clk),
        .rst       (rst),
        .rd_idx_i  (bim_idx),
        .rd_data_o (bim_rd),
        .wr_en_i   (fb_i.valid),
        .wr_idx_i  (bim_uidx),
        .wr_data_i (bim_wd),
        .wr_cur_o  (bim_cur)
    );

    bpu_table #(
        .entry_t   (bpu_pkg::tage_entry_t),
        .DEPTH     (bpu_pkg::TAGE_ENTRIES),
        .RESET_VAL ('0)
    ) u_t0 (
        .clk       (clk),
        .rst       (rst),
        .rd_idx_i  (t0_idx),
        .rd_data_o (t0_rd),
        .wr_en_i   (t0_we),
        .wr_idx_i  (t0_uidx),
        .wr_data_i (t0_wd),
        .wr_cur_o  (t0_cur)
    );

    bpu_table #(
        .entry_t   (bpu_pkg::tage_entry_t),
        .DEPTH     (bpu_pkg::TAGE_ENTRIES),
        .RESET_VAL ('0)
    ) u_t1 (
        .clk       (clk),
        .rst       (rst),
        .rd_idx_i  (t1_idx),
        .rd_data_o (t1_rd),
        .wr_en_i   (t1_we),
        .wr_idx_i  (t1_uidx),
        .wr_data_i (t1_wd),
        .wr_cur_o  (t1_cur)
    );

    provider_known_a: assert property (
        @(posedge clk) disable iff (rst) !$isunknown(provider_o)
    );

endmodule

/* bpu_btb.sv */
module bpu_btb (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [bpu_pkg::XLEN-1:0] pc_i,
    input  bpu_pkg::bpu_feedback_t   fb_i,
    output logic                     hit_o,
    output logic [bpu_pkg::XLEN-1:0] target_o
);

    logic [bpu_pkg::BTB_IDX_W-1:0] rd_idx;
    logic [bpu_pkg::BTB_TAG_W-1:0] rd_tag;
    logic [bpu_pkg::BTB_IDX_W-1:0] wr_idx;
    bpu_pkg::btb_entry_t           rd_entry;
    bpu_pkg::btb_entry_t           wr_entry;
    logic                          wr_en;

    // word aligned index, rest of the pc is the tag
    assign rd_idx = pc_i[bpu_pkg::BTB_IDX_W+1:2];
    assign rd_tag = pc_i[bpu_pkg::XLEN-1 -: bpu_pkg::BTB_TAG_W];

    assign hit_o    = rd_entry.valid && (rd_entry.tag == rd_tag);
    assign target_o = rd_entry.target;

    // only taken outcomes carry a useful target
    assign wr_en  = fb_i.valid && fb_i.taken;
    assign wr_idx = fb_i.pc[bpu_pkg::BTB_IDX_W+1:2];

    assign wr_entry = '{
        valid:  1'b1,
        tag:    fb_i.pc[bpu_pkg::XLEN-1 -: bpu_pkg::BTB_TAG_W],
        target: fb_i.target
    };

    bpu_table #(
        .entry_t   (bpu_pkg::btb_entry_t),
        .DEPTH     (bpu_pkg::BTB_ENTRIES),
        .RESET_VAL ('0)
    ) u_btb_mem (
        .clk       (clk),
        .rst       (rst),
        .rd_idx_i  (rd_idx),
        .rd_data_o (rd_entry),
        .wr_en_i   (wr_en),
        .wr_idx_i  (wr_idx),
        .wr_data_i (wr_entry),
        .wr_cur_o  ()            // plain overwrite, old entry not needed
    );

endmodule

/* bpu_next_pc.sv */
module bpu_next_pc (
    input  logic [bpu_pkg::XLEN-1:0]   pc_i,
    input  logic                       is_branch_i,
    input  logic                       is_jal_i,
    input  logic                       is_jalr_i,
    input  logic                       is_ret_i,
    input  logic [bpu_pkg::XLEN-1:0]   br_off_i,
    input  logic [bpu_pkg::XLEN-1:0]   jal_off_i,
    input  logic                       dir_taken_i,
    input  bpu_pkg::provider_e         provider_i,
    input  logic [bpu_pkg::HIST_W-1:0] history_i,
    input  logic                       btb_hit_i,
    input  logic [bpu_pkg::XLEN-1:0]   btb_target_i,
    output bpu_pkg::bpu_pred_t         pred_o
);

    logic [bpu_pkg::XLEN-1:0] pc_seq;

    assign pc_seq = pc_i + 4;

    always_comb begin
        pred_o          = '0;
        pred_o.target   = pc_seq;
        pred_o.provider = provider_i;
        pred_o.history  = history_i;
        if (is_ret_i) begin
            pred_o.is_ctrl = 1'b1;    // no return stack, fall through
        end else if (is_jal_i) begin
            pred_o.is_ctrl = 1'b1;
            pred_o.taken   = 1'b1;
            pred_o.target  = btb_hit_i ? btb_target_i : pc_i + jal_off_i;
        end else if (is_branch_i || is_jalr_i) begin
            pred_o.is_ctrl = 1'b1;
            pred_o.taken   = dir_taken_i;
            if (dir_taken_i) begin
                if (btb_hit_i) begin
                    pred_o.target = btb_target_i;
                end else if (is_branch_i) begin
                    pred_o.target = pc_i + br_off_i;
                end
                // jalr without a btb entry has no target, stays pc+4
            end
        end
    end

endmodule

/* bpu_top.sv */
module bpu_top (
    input  logic                   clk,
    input  logic                   rst,
    input  bpu_pkg::bpu_fetch_t    fetch_i,
    input  bpu_pkg::bpu_feedback_t fb_i,
    output bpu_pkg::bpu_pred_t     pred_o
);

    logic                       is_branch;
    logic                       is_jal;
    logic                       is_jalr;
    logic                       is_ret;
    logic [bpu_pkg::XLEN-1:0]   br_off;
    logic [bpu_pkg::XLEN-1:0]   jal_off;
    logic                       dir_taken;
    bpu_pkg::provider_e         provider;
    logic [bpu_pkg::HIST_W-1:0] history;
    logic                       btb_hit;
    logic [bpu_pkg::XLEN-1:0]   btb_target;

    bpu_predecode u_predecode (
        .inst_i      (fetch_i.inst),
        .is_branch_o (is_branch),
        .is_jal_o    (is_jal),
        .is_jalr_o   (is_jalr),
        .is_ret_o    (is_ret),
        .br_off_o    (br_off),
        .jal_off_o   (jal_off)
    );

    bpu_tage u_tage (
        .clk        (clk),
        .rst        (rst),
        .pc_i       (fetch_i.pc),
        .fb_i       (fb_i),
        .taken_o    (dir_taken),
        .provider_o (provider),
        .history_o  (history)
    );

    bpu_btb u_btb (
        .clk      (clk),
        .rst      (rst),
        .pc_i     (fetch_i.pc),
        .fb_i     (fb_i),
        .hit_o    (btb_hit),
        .target_o (btb_target)
    );

    bpu_next_pc u_next_pc (
        .pc_i         (fetch_i.pc),
        .is_branch_i  (is_branch),
        .is_jal_i     (is_jal),
        .is_jalr_i    (is_jalr),
        .is_ret_i     (is_ret),
        .br_off_i     (br_off),
        .jal_off_i    (jal_off),
        .dir_taken_i  (dir_taken),
        .provider_i   (provider),
        .history_i    (history),
        .btb_hit_i    (btb_hit),
        .btb_target_i (btb_target),
        .pred_o       (pred_o)
    );

endmodule

/* tb_bpu.sv */
module tb_bpu;

    timeunit 1ns;
    timeprecision 1ps;

    logic                  clk;
    logic                  rst;
    bpu_pkg::bpu_fetch_t    fetch;
    bpu_pkg::bpu_feedback_t fb;
    bpu_pkg::bpu_pred_t     pred;

    // expected prediction, checked at every rising edge while chk_en is high
    bpu_pkg::bpu_pred_t         exp_pred;
    logic                       chk_en;

    // shadow state built from the feedback stream
    logic [bpu_pkg::HIST_W-1:0] shadow_hist;
    logic [1:0]                 bim_ctr [bpu_pkg::BIM_ENTRIES];
    logic                       btb_vld [bpu_pkg::BTB_ENTRIES];
    logic [31:0]                btb_pc  [bpu_pkg::BTB_ENTRIES];
    logic [31:0]                btb_tgt [bpu_pkg::BTB_ENTRIES];

    logic [31:0] pc_a;
    logic [31:0] pc_b;
    logic [31:0] tgt;
    logic [31:0] off;
    logic [bpu_pkg::HIST_W-1:0] next_hist;

    bpu_top UUT (
        .clk     (clk),
        .rst     (rst),
        .fetch_i (fetch),
        .fb_i    (fb),
        .pred_o  (pred)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] got,
                                   input logic [31:0] want);
        abort_run($sformatf("mismatch %s: got %0h expected %0h", sig, got, want));
    endtask

    is_ctrl_a: assert property (@(posedge clk) disable iff (rst)
        chk_en |-> pred.is_ctrl == exp_pred.is_ctrl)
        else report_mismatch("pred_o.is_ctrl", $sampled(pred.is_ctrl),
                             $sampled(exp_pred.is_ctrl));

    taken_a: assert property (@(posedge clk) disable iff (rst)
        chk_en |-> pred.taken == exp_pred.taken)
        else report_mismatch("pred_o.taken", $sampled(pred.taken), $sampled(exp_pred.taken));

    target_a: assert property (@(posedge clk) disable iff (rst)
        chk_en |-> pred.target == exp_pred.target)
        else report_mismatch("pred_o.target", $sampled(pred.target),
                             $sampled(exp_pred.target));

    provider_a: assert property (@(posedge clk) disable iff (rst)
        chk_en |-> pred.provider == exp_pred.provider)
        else report_mismatch("pred_o.provider", $sampled(pred.provider),
                             $sampled(exp_pred.provider));

    history_a: assert property (@(posedge clk) disable iff (rst)
        chk_en |-> pred.history == exp_pred.history)
        else report_mismatch("pred_o.history", $sampled(pred.history),
                             $sampled(exp_pred.history));

    function automatic logic [31:0] rand_pc();
        return $urandom() & 32'hffff_fffc;    // word aligned
    endfunction

    function automatic logic [31:0] rand_jal_off();
        logic [31:0] r;
        r = $urandom();
        return {{11{r[20]}}, r[20:1], 1'b0};
    endfunction

    function automatic logic [31:0] rand_br_off();
        logic [31:0] r;
        r = $urandom();
        return {{19{r[12]}}, r[12:1], 1'b0};
    endfunction

    // jal ra, off
    function automatic logic [31:0] enc_jal(input logic [31:0] o);
        return {o[20], o[10:1], o[11], o[19:12], 5'd1, bpu_pkg::OP_JAL};
    endfunction

    // beq x1, x2, off
    function automatic logic [31:0] enc_branch(input logic [31:0] o);
        return {o[12], o[10:5], 5'd2, 5'd1, 3'b000, o[4:1], o[11], bpu_pkg::OP_BRANCH};
    endfunction

    function automatic logic [1:0] sat_move(input logic [1:0] ctr, input logic up);
        if (up) begin
            return (ctr == 2'b11) ? ctr : ctr + 2'b01;
        end
        return (ctr == 2'b00) ? ctr : ctr - 2'b01;
    endfunction

    // btb target on a shadow hit, else the given fallback
    function automatic logic [31:0] btb_or(input logic [31:0] pc, input logic [31:0] fallback);
        logic [7:0] idx;
        idx = pc[9:2];
        if (btb_vld[idx] && (btb_pc[idx][31:10] == pc[31:10])) begin
            return btb_tgt[idx];
        end
        return fallback;
    endfunction

    // drive one fetch and arm the checks for the next rising edge
    task automatic check_pred(input logic [31:0] pc, input logic [31:0] inst,
                              input logic is_ctrl, input logic taken,
                              input logic [31:0] target, input bpu_pkg::provider_e prov);
        fetch    = '{pc: pc, inst: inst};
        exp_pred = '{is_ctrl: is_ctrl, taken: taken, target: target,
                     provider: prov, history: shadow_hist};
        chk_en   = 1'b1;
        @(negedge clk);
        chk_en = 1'b0;
    endtask

    task automatic check_jal(input logic [31:0] pc, input logic [31:0] o);
        check_pred(pc, enc_jal(o), 1'b1, 1'b1, btb_or(pc, pc + o), bpu_pkg::PROV_BIM);
    endtask

    // direction from the shadow bimodal counter
    task automatic check_branch(input logic [31:0] pc, input logic [31:0] o);
        logic dir;
        dir = bim_ctr[pc[9:1]][1];
        check_pred(pc, enc_branch(o), 1'b1, dir, dir ? btb_or(pc, pc + o) : pc + 4,
                   bpu_pkg::PROV_BIM);
    endtask

    task automatic wait_history();
        int cycles;
        cycles = 0;
        while (pred.history !== shadow_hist) begin
            if (cycles == 8) begin
                abort_run("history did not follow the feedback in time");
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    task automatic send_feedback(input logic [31:0] pc, input logic taken,
                                 input logic pred_taken, input bpu_pkg::provider_e prov,
                                 input logic [bpu_pkg::HIST_W-1:0] hist,
                                 input logic [31:0] target);
        fb = '{valid: 1'b1, taken: taken, pred_taken: pred_taken, provider: prov,
               pc: pc, history: hist, target: target};
        @(negedge clk);
        fb.valid = 1'b0;
        shadow_hist = {shadow_hist[bpu_pkg::HIST_W-2:0], taken};
        bim_ctr[pc[9:1]] = sat_move(bim_ctr[pc[9:1]], taken);
        if (taken) begin
            btb_vld[pc[9:2]] = 1'b1;
            btb_pc[pc[9:2]]  = pc;
            btb_tgt[pc[9:2]] = target;
        end
        wait_history();
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while ($isunknown(pred)) begin
            if (cycles == 8) begin
                abort_run("prediction still unknown after reset");
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    initial begin
        void'($urandom(32'hb909_1401));
        rst         = 1'b1;
        fetch       = '0;
        fb          = '0;
        exp_pred    = '0;
        chk_en      = 1'b0;
        shadow_hist = '0;
        for (int i = 0; i < bpu_pkg::BIM_ENTRIES; i++) begin
            bim_ctr[i] = 2'b01;
        end
        for (int i = 0; i < bpu_pkg::BTB_ENTRIES; i++) begin
            btb_vld[i] = 1'b0;
            btb_pc[i]  = '0;
            btb_tgt[i] = '0;
        end
        repeat (16) @(negedge clk);
        rst = 1'b0;
        wait_reset_release();

        // fall through cases, addi and ret
        pc_a = rand_pc();
        check_pred(pc_a, 32'h0000_0013, 1'b0, 1'b0, pc_a + 4, bpu_pkg::PROV_BIM);
        pc_a = rand_pc();
        check_pred(pc_a, 32'h0000_8067, 1'b1, 1'b0, pc_a + 4, bpu_pkg::PROV_BIM);

        // empty btb
        check_jal(rand_pc(), rand_jal_off());
        check_branch(rand_pc(), rand_br_off());

        // history follows correctly predicted feedback
        for (int i = 0; i < 8; i++) begin
            logic dir;
            dir = $urandom_range(0, 1);
            send_feedback(rand_pc(), dir, dir, bpu_pkg::PROV_BIM, shadow_hist, rand_pc());
            pc_a = rand_pc();
            check_pred(pc_a, 32'h0000_0013, 1'b0, 1'b0, pc_a + 4, bpu_pkg::PROV_BIM);
        end

        // btb hit, then same index with another tag
        pc_a = rand_pc();
        tgt  = rand_pc();
        send_feedback(pc_a, 1'b1, 1'b1, bpu_pkg::PROV_BIM, shadow_hist, tgt);
        check_jal(pc_a, rand_jal_off());
        check_jal(pc_a ^ 32'h0010_0000, rand_jal_off());

        // bimodal trains 01 -> 11
        pc_b = rand_pc();
        tgt  = rand_pc();
        off  = rand_br_off();
        send_feedback(pc_b, 1'b1, 1'b1, bpu_pkg::PROV_BIM, shadow_hist, tgt);
        send_feedback(pc_b, 1'b1, 1'b1, bpu_pkg::PROV_BIM, shadow_hist, tgt);
        check_branch(pc_b, off);

        // bimodal mispredict allocates in T1
        pc_b      = rand_pc();
        next_hist = {shadow_hist[bpu_pkg::HIST_W-2:0], 1'b0};
        send_feedback(pc_b, 1'b0, 1'b1, bpu_pkg::PROV_BIM, next_hist, '0);
        check_pred(pc_b, enc_branch(rand_br_off()), 1'b1, 1'b0, pc_b + 4, bpu_pkg::PROV_T1);

        $display("RESULT: PASS");
        $finish;
    end

endmodule

/* bpu.f */
bpu_pkg.sv
bpu_table.sv
bpu_predecode.sv
bpu_tage.sv
bpu_btb.sv
bpu_next_pc.sv
bpu_top.sv
tb_bpu.sv
